/* Makefile */
SOURCES := tb.f $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

all: run

obj_dir/Vperf_tb: $(SOURCES)
	verilator --binary --timing --top-module perf_tb -f tb.f -Mdir obj_dir -o Vperf_tb

run: obj_dir/Vperf_tb
	./obj_dir/Vperf_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* hdl/axis_buf.sv */
`default_nettype none

module axis_buf (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic                              s_tvalid,
    input  wire logic [perf_pkg::axis_data_w-1:0]  s_tdata,
    input  wire logic                              s_tlast,
    output logic                                   s_tready,
    output logic                                   m_tvalid,
    output logic [perf_pkg::axis_data_w-1:0]       m_tdata,
    output logic                                   m_tlast,
    input  wire logic                              m_tready
);
    import perf_pkg::*;

    logic [axis_data_w:0]   mem [buf_depth];  // {tlast, tdata}
    logic [buf_ptr_w-1:0]   wr_ptr;
    logic [buf_ptr_w-1:0]   rd_ptr;
    logic [buf_ptr_w:0]     count;
    logic                   push;
    logic                   pop;

    assign s_tready          = (count != (buf_ptr_w + 1)'(buf_depth));
    assign m_tvalid          = (count != '0);
    assign {m_tlast, m_tdata} = mem[rd_ptr];
    assign push              = s_tvalid && s_tready;
    assign pop               = m_tvalid && m_tready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= {s_tlast, s_tdata};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/perf_axil_regs.sv */
`default_nettype none

module perf_axil_regs (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [perf_pkg::axil_addr_w-1:0]    awaddr,
    input  wire logic                                wvalid,
    output logic                                     wready,
    input  wire logic [perf_pkg::axil_data_w-1:0]    wdata,
    input  wire logic [perf_pkg::axil_data_w/8-1:0]  wstrb,
    output logic                                     bvalid,
    input  wire logic                                bready,
    output logic [1:0]                               bresp,
    input  wire logic                                arvalid,
    output logic                                     arready,
    input  wire logic [perf_pkg::axil_addr_w-1:0]    araddr,
    output logic                                     rvalid,
    input  wire logic                                rready,
    output logic [perf_pkg::axil_data_w-1:0]         rdata,
    output logic [1:0]                               rresp,
    output logic                                     start,
    output logic [perf_pkg::cnt_w-1:0]               beat_num,
    output logic [perf_pkg::cnt_w-1:0]               pkt_num,
    input  wire logic                                tx_busy,
    input  wire logic                                rx_busy,
    input  wire logic [perf_pkg::cnt_w-1:0]          tx_cycles,
    input  wire logic [perf_pkg::cnt_w-1:0]          tx_beats,
    input  wire logic [perf_pkg::cnt_w-1:0]          tx_pkts,
    input  wire logic [perf_pkg::cnt_w-1:0]          rx_cycles,
    input  wire logic [perf_pkg::cnt_w-1:0]          rx_beats,
    input  wire logic [perf_pkg::cnt_w-1:0]          rx_errs,
    input  wire logic [perf_pkg::cnt_w-1:0]          rx_pkts
);
    import perf_pkg::*;

    axil_state_e              state;
    logic                     aw_held;
    logic                     w_held;
    logic [axil_addr_w-1:0]   aw_addr_q;
    logic [axil_data_w-1:0]   w_data_q;
    logic [axil_data_w/8-1:0] w_strb_q;

    logic                     aw_hs;
    logic                     w_hs;
    logic                     ar_hs;
    logic                     wr_go;
    logic [axil_addr_w-1:0]   wr_addr;
    logic [axil_data_w-1:0]   wr_data;
    logic [axil_data_w/8-1:0] wr_strb;
    perf_reg_e                wr_reg;
    perf_reg_e                rd_reg;
    logic                     wr_in_map;
    logic                     rd_in_map;
    logic [axil_data_w-1:0]   rd_val;

    // byte-lane merge for the writable registers
    function automatic logic [cnt_w-1:0] merge_bytes(
        input logic [cnt_w-1:0]         old_val,
        input logic [axil_data_w-1:0]   new_val,
        input logic [axil_data_w/8-1:0] strb
    );
        logic [cnt_w-1:0] res;
        res = old_val;
        for (int i = 0; i < axil_data_w / 8; i++) begin
            if (strb[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    assign awready = (state == idle) && !aw_held;
    assign wready  = (state == idle) && !w_held;
    assign arready = (state == idle) && !aw_held && !w_held && !awvalid && !wvalid;  // writes first
    assign bvalid  = (state == write_resp);
    assign rvalid  = (state == read_data);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;
    assign wr_go = (aw_held || aw_hs) && (w_held || w_hs);

    // captured half or the one arriving this cycle
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb;

    assign wr_reg    = perf_reg_e'(wr_addr[5:2]);
    assign rd_reg    = perf_reg_e'(araddr[5:2]);
    assign wr_in_map = (wr_addr[axil_addr_w-1:6] == '0) && (wr_reg <= reg_pkt_num);
    assign rd_in_map = (araddr[axil_addr_w-1:6] == '0) && (rd_reg <= reg_rx_pkts);

    always_comb begin
        case (rd_reg)
            reg_beat_num:  rd_val = beat_num;
            reg_pkt_num:   rd_val = pkt_num;
            reg_status:    rd_val = {{(axil_data_w-2){1'b0}}, rx_busy, tx_busy};
            reg_tx_cycles: rd_val = tx_cycles;
            reg_tx_beats:  rd_val = tx_beats;
            reg_tx_pkts:   rd_val = tx_pkts;
            reg_rx_cycles: rd_val = rx_cycles;
            reg_rx_beats:  rd_val = rx_beats;
            reg_rx_errs:   rd_val = rx_errs;
            reg_rx_pkts:   rd_val = rx_pkts;
            default:       rd_val = '0;  // ctrl is write-only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            start    <= 1'b0;
            beat_num <= '0;
            pkt_num  <= '0;
            bresp    <= resp_okay;
            rdata    <= '0;
            rresp    <= resp_okay;
        end else begin
            start <= 1'b0;
            case (state)
                idle: begin
                    if (wr_go) begin
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                        state   <= write_resp;
                        bresp   <= wr_in_map ? resp_okay : resp_slverr;
                        if (wr_in_map) begin
                            case (wr_reg)
                                reg_ctrl:     start <= wr_strb[0] && wr_data[0]
                                                       && !tx_busy && !rx_busy;
                                reg_beat_num: beat_num <= merge_bytes(beat_num, wr_data, wr_strb);
                                reg_pkt_num:  pkt_num <= merge_bytes(pkt_num, wr_data, wr_strb);
                                default:      ;
                            endcase
                        end
                    end else begin
                        if (aw_hs) begin
                            aw_held   <= 1'b1;
                            aw_addr_q <= awaddr;
                        end
                        if (w_hs) begin
                            w_held   <= 1'b1;
                            w_data_q <= wdata;
                            w_strb_q <= wstrb;
                        end
                        if (ar_hs) begin
                            state <= read_data;
                            rdata <= rd_in_map ? rd_val : '0;
                            rresp <= rd_in_map ? resp_okay : resp_slverr;
                        end
                    end
                end
                write_resp: if (bready) state <= idle;
                read_data:  if (rready) state <= idle;
                default:    state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/perf_mon_top.sv */
`default_nettype none

module perf_mon_top (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [perf_pkg::axil_addr_w-1:0]    awaddr,
    input  wire logic                                wvalid,
    output logic                                     wready,
    input  wire logic [perf_pkg::axil_data_w-1:0]    wdata,
    input  wire logic [perf_pkg::axil_data_w/8-1:0]  wstrb,
    output logic                                     bvalid,
    input  wire logic                                bready,
    output logic [1:0]                               bresp,
    input  wire logic                                arvalid,
    output logic                                     arready,
    input  wire logic [perf_pkg::axil_addr_w-1:0]    araddr,
    output logic                                     rvalid,
    input  wire logic                                rready,
    output logic [perf_pkg::axil_data_w-1:0]         rdata,
    output logic [1:0]                               rresp,
    output logic                                     tx_tvalid,
    output logic [perf_pkg::axis_data_w-1:0]         tx_tdata,
    output logic                                     tx_tlast,
    input  wire logic                                tx_tready,
    input  wire logic                                rx_tvalid,
    input  wire logic [perf_pkg::axis_data_w-1:0]    rx_tdata,
    input  wire logic                                rx_tlast,
    output logic                                     rx_tready
);
    import perf_pkg::*;

    logic                   start;
    logic [cnt_w-1:0]       beat_num;
    logic [cnt_w-1:0]       pkt_num;
    logic                   tx_busy;
    logic                   rx_busy;
    logic [cnt_w-1:0]       tx_cycles;
    logic [cnt_w-1:0]       tx_beats;
    logic [cnt_w-1:0]       tx_pkts;
    logic [cnt_w-1:0]       rx_cycles;
    logic [cnt_w-1:0]       rx_beats;
    logic [cnt_w-1:0]       rx_errs;
    logic [cnt_w-1:0]       rx_pkts;

    // generator to transmit buffer
    logic                   gen_tvalid;
    logic [axis_data_w-1:0] gen_tdata;
    logic                   gen_tlast;
    logic                   gen_tready;

    // receive buffer to checker
    logic                   chk_tvalid;
    logic [axis_data_w-1:0] chk_tdata;
    logic                   chk_tlast;
    logic                   chk_tready;

    perf_axil_regs u_regs (
        .clk,
        .reset,
        .awvalid,
        .awready,
        .awaddr,
        .wvalid,
        .wready,
        .wdata,
        .wstrb,
        .bvalid,
        .bready,
        .bresp,
        .arvalid,
        .arready,
        .araddr,
        .rvalid,
        .rready,
        .rdata,
        .rresp,
        .start,
        .beat_num,
        .pkt_num,
        .tx_busy,
        .rx_busy,
        .tx_cycles,
        .tx_beats,
        .tx_pkts,
        .rx_cycles,
        .rx_beats,
        .rx_errs,
        .rx_pkts
    );

    perf_tx_gen u_gen (
        .clk,
        .reset,
        .start,
        .beat_num,
        .pkt_num,
        .gen_tvalid,
        .gen_tdata,
        .gen_tlast,
        .gen_tready,
        .tx_busy,
        .tx_cycles,
        .tx_beats,
        .tx_pkts
    );

    axis_buf u_tx_buf (
        .clk      (clk),
        .reset    (reset),
        .s_tvalid (gen_tvalid),
        .s_tdata  (gen_tdata),
        .s_tlast  (gen_tlast),
        .s_tready (gen_tready),
        .m_tvalid (tx_tvalid),
        .m_tdata  (tx_tdata),
        .m_tlast  (tx_tlast),
        .m_tready (tx_tready)
    );

    axis_buf u_rx_buf (
        .clk      (clk),
        .reset    (reset),
        .s_tvalid (rx_tvalid),
        .s_tdata  (rx_tdata),
        .s_tlast  (rx_tlast),
        .s_tready (rx_tready),
        .m_tvalid (chk_tvalid),
        .m_tdata  (chk_tdata),
        .m_tlast  (chk_tlast),
        .m_tready (chk_tready)
    );

    perf_rx_check u_chk (
        .clk,
        .reset,
        .start,
        .beat_num,
        .pkt_num,
        .chk_tvalid,
        .chk_tdata,
        .chk_tlast,
        .chk_tready,
        .rx_busy,
        .rx_cycles,
        .rx_beats,
        .rx_errs,
        .rx_pkts
    );

endmodule

`default_nettype wire

/* hdl/perf_pkg.sv */
`default_nettype none

package perf_pkg;

    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 32;
    localparam int axis_data_w = 64;
    localparam int buf_depth   = 16;
    localparam int buf_ptr_w   = 4;
    localparam int cnt_w       = 32;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    // word index, byte address divided by 4
    typedef enum logic [3:0] {
        reg_ctrl      = 4'd0,  // bit 0 starts a run
        reg_beat_num  = 4'd1,
        reg_pkt_num   = 4'd2,
        reg_status    = 4'd3,  // {rx_busy, tx_busy}
        reg_tx_cycles = 4'd4,
        reg_tx_beats  = 4'd5,
        reg_tx_pkts   = 4'd6,
        reg_rx_cycles = 4'd7,
        reg_rx_beats  = 4'd8,
        reg_rx_errs   = 4'd9,
        reg_rx_pkts   = 4'd10
    } perf_reg_e;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        write_resp = 2'd1,
        read_data  = 2'd2
    } axil_state_e;

    typedef enum logic {
        run_idle   = 1'b0,
        run_active = 1'b1
    } run_state_e;

endpackage

`default_nettype wire

/* hdl/perf_rx_check.sv */
`default_nettype none

module perf_rx_check (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic                              start,
    input  wire logic [perf_pkg::cnt_w-1:0]        beat_num,
    input  wire logic [perf_pkg::cnt_w-1:0]        pkt_num,
    input  wire logic                              chk_tvalid,
    input  wire logic [perf_pkg::axis_data_w-1:0]  chk_tdata,
    input  wire logic                              chk_tlast,
    output logic                                   chk_tready,
    output logic                                   rx_busy,
    output logic [perf_pkg::cnt_w-1:0]             rx_cycles,
    output logic [perf_pkg::cnt_w-1:0]             rx_beats,
    output logic [perf_pkg::cnt_w-1:0]             rx_errs,
    output logic [perf_pkg::cnt_w-1:0]             rx_pkts
);
    import perf_pkg::*;

    run_state_e       state;
    logic [cnt_w-1:0] exp_pkt;
    logic [cnt_w-1:0] exp_beat;
    logic             exp_last;
    logic             first_seen;
    logic             beat;
    logic             mismatch;

    assign chk_tready = 1'b1;  // checker always sinks
    assign rx_busy    = (state == run_active);
    assign beat       = chk_tvalid && (state == run_active);
    assign exp_last   = (exp_beat == beat_num - 1'b1);
    assign mismatch   = (chk_tdata != {exp_pkt, exp_beat}) || (chk_tlast != exp_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= run_idle;
            exp_pkt    <= '0;
            exp_beat   <= '0;
            first_seen <= 1'b0;
            rx_cycles  <= '0;
            rx_beats   <= '0;
            rx_errs    <= '0;
            rx_pkts    <= '0;
        end else if (start) begin
            if (beat_num != '0 && pkt_num != '0)
                state <= run_active;
            exp_pkt    <= '0;
            exp_beat   <= '0;
            first_seen <= 1'b0;
            rx_cycles  <= '0;
            rx_beats   <= '0;
            rx_errs    <= '0;
            rx_pkts    <= '0;
        end else if (state == run_active) begin
            if (beat || first_seen)
                rx_cycles <= rx_cycles + 1'b1;
            if (beat) begin
                first_seen <= 1'b1;
                rx_beats   <= rx_beats + 1'b1;
                if (mismatch)
                    rx_errs <= rx_errs + 1'b1;
                // expected indices follow the pattern, not the received tlast
                if (exp_last) begin
                    exp_beat <= '0;
                    exp_pkt  <= exp_pkt + 1'b1;
                end else begin
                    exp_beat <= exp_beat + 1'b1;
                end
                if (chk_tlast) begin
                    rx_pkts <= rx_pkts + 1'b1;
                    if (rx_pkts == pkt_num - 1'b1)
                        state <= run_idle;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/perf_tx_gen.sv */
`default_nettype none

module perf_tx_gen (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic                              start,
    input  wire logic [perf_pkg::cnt_w-1:0]        beat_num,
    input  wire logic [perf_pkg::cnt_w-1:0]        pkt_num,
    output logic                                   gen_tvalid,
    output logic [perf_pkg::axis_data_w-1:0]       gen_tdata,
    output logic                                   gen_tlast,
    input  wire logic                              gen_tready,
    output logic                                   tx_busy,
    output logic [perf_pkg::cnt_w-1:0]             tx_cycles,
    output logic [perf_pkg::cnt_w-1:0]             tx_beats,
    output logic [perf_pkg::cnt_w-1:0]             tx_pkts
);
    import perf_pkg::*;

    run_state_e       state;
    logic [cnt_w-1:0] pkt_idx;
    logic [cnt_w-1:0] beat_idx;
    logic             first_seen;  // first beat already accepted
    logic             hs;

    assign gen_tvalid = (state == run_active);
    assign gen_tdata  = {pkt_idx, beat_idx};  // counting pattern
    assign gen_tlast  = (beat_idx == beat_num - 1'b1);
    assign tx_busy    = (state == run_active);
    assign hs         = gen_tvalid && gen_tready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= run_idle;
            pkt_idx    <= '0;
            beat_idx   <= '0;
            first_seen <= 1'b0;
            tx_cycles  <= '0;
            tx_beats   <= '0;
            tx_pkts    <= '0;
        end else if (start) begin
            // an empty run never goes active
            if (beat_num != '0 && pkt_num != '0)
                state <= run_active;
            pkt_idx    <= '0;
            beat_idx   <= '0;
            first_seen <= 1'b0;
            tx_cycles  <= '0;
            tx_beats   <= '0;
            tx_pkts    <= '0;
        end else if (state == run_active) begin
            if (hs || first_seen)
                tx_cycles <= tx_cycles + 1'b1;
            if (hs) begin
                first_seen <= 1'b1;
                tx_beats   <= tx_beats + 1'b1;
                if (gen_tlast) begin
                    beat_idx <= '0;
                    pkt_idx  <= pkt_idx + 1'b1;
                    tx_pkts  <= tx_pkts + 1'b1;
                    if (pkt_idx == pkt_num - 1'b1)
                        state <= run_idle;  // last beat of last packet
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/perf_pkg.sv
hdl/axis_buf.sv
hdl/perf_axil_regs.sv
hdl/perf_tx_gen.sv
hdl/perf_rx_check.sv
hdl/perf_mon_top.sv
tests/perf_tb.sv

/* tests/perf_tb.sv */
`default_nettype none

module perf_tb;
    import perf_pkg::*;

    localparam int drive_dly   = 1;
    localparam int cycle_limit = 4000;  // (24+35+12+24) beats x4 plus register traffic
    localparam int poll_limit  = 200;

    logic                     clk;
    logic                     reset;
    logic                     awvalid;
    logic                     awready;
    logic [axil_addr_w-1:0]   awaddr;
    logic                     wvalid;
    logic                     wready;
    logic [axil_data_w-1:0]   wdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic                     bvalid;
    logic                     bready;
    logic [1:0]               bresp;
    logic                     arvalid;
    logic                     arready;
    logic [axil_addr_w-1:0]   araddr;
    logic                     rvalid;
    logic                     rready;
    logic [axil_data_w-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     tx_tvalid;
    logic [axis_data_w-1:0]   tx_tdata;
    logic                     tx_tlast;
    logic                     tx_tready;
    logic                     rx_tvalid;
    logic [axis_data_w-1:0]   rx_tdata;
    logic                     rx_tlast;
    logic                     rx_tready;

    logic                     bp_on;       // random back-pressure on the loopback
    logic                     flip_on;     // corrupt beat 2 of packet 1
    logic                     ready_gate;
    logic [31:0]              lcg_state;
    logic [axis_data_w-1:0]   flip_mask;
    logic [31:0]              mon_pkt;     // packet index expected on the transmit port
    logic [31:0]              mon_beat;
    logic [31:0]              last_beat;
    int                       cycle_count;
    int                       mismatches;
    int                       failures;

    perf_mon_top u_dut (.*);

    always #20 clk = ~clk;

    // loopback outside the DUT
    assign flip_mask = (flip_on && tx_tdata == {32'd1, 32'd2}) ? 64'd1 : 64'd0;
    assign rx_tvalid = tx_tvalid && ready_gate;
    assign rx_tdata  = tx_tdata ^ flip_mask;
    assign rx_tlast  = tx_tlast;
    assign tx_tready = rx_tready && ready_gate;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [axil_addr_w-1:0] reg_addr(input logic [3:0] idx);
        return {{(axil_addr_w-6){1'b0}}, idx, 2'b00};
    endfunction

    always @(posedge clk) begin
        #drive_dly;
        if (bp_on) begin
            lcg_state = lcg_next(lcg_state);
            ready_gate = (lcg_state[31:30] != 2'b00);  // ready about 3 cycles in 4
        end else begin
            ready_gate = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("mismatches %0d, other failures %0d", mismatches, failures + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [axil_data_w-1:0] got,
                              input logic [axil_data_w-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_beat(input logic [axis_data_w-1:0] got_data, input logic got_last,
                              input logic [axis_data_w-1:0] exp_data, input logic exp_last);
        if (got_data !== exp_data) begin
            $display("MISMATCH tx_tdata got %h expected %h", got_data, exp_data);
            mismatches++;
        end
        if (got_last !== exp_last) begin
            $display("MISMATCH tx_tlast got %h expected %h", got_last, exp_last);
            mismatches++;
        end
    endtask

    // transmit port against the counting pattern
    always @(posedge clk) begin
        if (!reset && tx_tvalid && tx_tready) begin
            check_beat(tx_tdata, tx_tlast, {mon_pkt, mon_beat}, mon_beat == last_beat);
            if (mon_beat == last_beat) begin
                mon_beat = '0;
                mon_pkt  = mon_pkt + 1;
            end else begin
                mon_beat = mon_beat + 1;
            end
        end
        if (!reset && rx_tready !== 1'b1) begin
            $display("rx_tready low although the checker never back-pressures");
            failures++;
        end
    end

    // called and returns a drive delay after a rising edge
    task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                              input logic [axil_data_w-1:0] data, output logic [1:0] resp);
        logic aw_now;
        logic w_now;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (awvalid || wvalid) begin
            aw_now = awvalid && awready;
            w_now  = wvalid && wready;
            @(posedge clk);
            #drive_dly;
            if (aw_now)
                awvalid = 1'b0;
            if (w_now)
                wvalid = 1'b0;
        end
        while (!bvalid) begin
            @(posedge clk);
            #drive_dly;
        end
        resp = bresp;
        @(posedge clk);
        #drive_dly;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr,
                             output logic [axil_data_w-1:0] data, output logic [1:0] resp);
        logic ar_now;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        ar_now  = 1'b0;
        while (!ar_now) begin
            ar_now = arready;
            @(posedge clk);
            #drive_dly;
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge clk);
            #drive_dly;
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #drive_dly;
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [axil_data_w-1:0] status;
        logic [1:0]             resp;
        int                     polls;
        polls = 0;
        do begin
            axil_read(reg_addr(reg_status), status, resp);
            polls++;
        end while (status != '0 && polls < poll_limit);
        if (status != '0) begin
            $display("status still busy after %0d polls", polls);
            failures++;
        end
    endtask

    task automatic start_run(input int beats, input int pkts);
        logic [1:0] resp;
        mon_pkt   = '0;
        mon_beat  = '0;
        last_beat = beats - 1;
        axil_write(reg_addr(reg_beat_num), beats, resp);
        check_resp("bresp beat_num", resp, resp_okay);
        axil_write(reg_addr(reg_pkt_num), pkts, resp);
        check_resp("bresp pkt_num", resp, resp_okay);
        axil_write(reg_addr(reg_ctrl), 32'd1, resp);
        check_resp("bresp ctrl", resp, resp_okay);
    endtask

    task automatic run_traffic(input int beats, input int pkts, input logic bp, input logic flip);
        bp_on   = bp;
        flip_on = flip;
        start_run(beats, pkts);
        wait_idle();
        bp_on   = 1'b0;
        flip_on = 1'b0;
    endtask

    task automatic check_counters(input int beats, input int pkts, input int errs,
                                  input logic exact_cycles);
        logic [axil_data_w-1:0] val;
        logic [1:0]             resp;
        check_data("tx port packets", mon_pkt, pkts);
        check_data("tx port beats past last packet", mon_beat, 32'd0);
        axil_read(reg_addr(reg_tx_beats), val, resp);
        check_data("tx_beats", val, beats * pkts);
        axil_read(reg_addr(reg_tx_pkts), val, resp);
        check_data("tx_pkts", val, pkts);
        axil_read(reg_addr(reg_rx_beats), val, resp);
        check_data("rx_beats", val, beats * pkts);
        axil_read(reg_addr(reg_rx_pkts), val, resp);
        check_data("rx_pkts", val, pkts);
        axil_read(reg_addr(reg_rx_errs), val, resp);
        check_data("rx_errs", val, errs);
        axil_read(reg_addr(reg_status), val, resp);
        check_data("status", val, 32'd0);
        axil_read(reg_addr(reg_tx_cycles), val, resp);
        if (exact_cycles) begin
            check_data("tx_cycles", val, beats * pkts);
        end else if (val < beats * pkts) begin
            $display("tx_cycles %0d is shorter than the %0d beats sent", val, beats * pkts);
            failures++;
        end
        axil_read(reg_addr(reg_rx_cycles), val, resp);
        if (val < beats * pkts) begin
            $display("rx_cycles %0d is shorter than the %0d beats received", val, beats * pkts);
            failures++;
        end
    endtask

    initial begin
        logic [axil_data_w-1:0] val;
        logic [1:0]             resp;
        clk         = 1'b0;
        reset       = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        bp_on       = 1'b0;
        flip_on     = 1'b0;
        ready_gate  = 1'b1;
        lcg_state   = 32'ha5b3_b552;
        mon_pkt     = '0;
        mon_beat    = '0;
        last_beat   = '0;
        cycle_count = 0;
        mismatches  = 0;
        failures    = 0;
        repeat (16) @(posedge clk);
        #drive_dly;
        reset = 1'b0;

        for (int i = 0; i <= 10; i++) begin  // everything zero after reset
            axil_read(reg_addr(4'(i)), val, resp);
            check_data($sformatf("reg %0d", i), val, 32'd0);
            check_resp($sformatf("rresp reg %0d", i), resp, resp_okay);
        end

        axil_write(reg_addr(reg_beat_num), 32'd5, resp);
        check_resp("bresp beat_num", resp, resp_okay);
        axil_write(reg_addr(reg_pkt_num), 32'd3, resp);
        check_resp("bresp pkt_num", resp, resp_okay);
        axil_read(reg_addr(reg_beat_num), val, resp);
        check_data("beat_num", val, 32'd5);
        axil_read(reg_addr(reg_pkt_num), val, resp);
        check_data("pkt_num", val, 32'd3);
        axil_write(reg_addr(4'd11), 32'hdead_beef, resp);
        check_resp("bresp unmapped", resp, resp_slverr);
        axil_read(reg_addr(4'd11), val, resp);
        check_data("rdata unmapped", val, 32'd0);
        check_resp("rresp unmapped", resp, resp_slverr);

        run_traffic(4, 6, 1'b0, 1'b0);
        check_counters(4, 6, 0, 1'b1);

        run_traffic(7, 5, 1'b1, 1'b0);
        check_counters(7, 5, 0, 1'b0);

        run_traffic(4, 3, 1'b0, 1'b1);  // one corrupted beat
        check_counters(4, 3, 1, 1'b1);

        start_run(4, 6);
        axil_read(reg_addr(reg_status), val, resp);
        if (val == '0) begin
            $display("run was not busy when the second start was written");
            failures++;
        end
        axil_write(reg_addr(reg_ctrl), 32'd1, resp);
        check_resp("bresp ctrl while busy", resp, resp_okay);
        wait_idle();
        check_counters(4, 6, 0, 1'b1);

        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
